// ==== list.f ====
design/isaPkg.sv
design/ctrlPkg.sv
design/instrQueue.sv
design/stepControl.sv
design/aluUnit.sv
design/busDatapath.sv
design/cpuTop.sv
verif/cpuTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module cpuTb -f list.f -o cpuSim

# The simulator exits nonzero on a failed check, the log decides the result
./obj_dir/cpuSim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Verification passed$" sim.log; then
    echo "run.sh: simulation PASS"
    exit 0
else
    echo "run.sh: simulation FAIL"
    exit 1
fi

// ==== verif/cpuTb.sv ====
`default_nettype none

module cpuTb;
    timeunit 1ns;
    timeprecision 100ps;

    import isaPkg::*;

    localparam int queueDepth = 4;
    localparam int resetCycles = 8;
    localparam int cyclesPerRow = 40;  // Watchdog budget per table row
    localparam int maxAckDelay = 12;

    logic clock;
    logic arstN;
    logic instrReq;
    logic [dataWidth-1:0] instrWord;
    logic instrAck;
    logic wbReq;
    regIndexT wbReg;
    logic [dataWidth-1:0] wbData;
    logic wbAck;

    // Instruction table, one entry per row
    logic [dataWidth-1:0] wordTab[$];
    bit hasResultTab[$];
    regIndexT expRegTab[$];
    logic [dataWidth-1:0] expValTab[$];
    int burstStart;  // First row of the back-pressure burst
    int stallCount;

    cpuTop #(
        .queueDepth (queueDepth)
    ) DUT (
        .clock     (clock),
        .arstN     (arstN),
        .instrReq  (instrReq),
        .instrWord (instrWord),
        .wbAck     (wbAck),
        .instrAck  (instrAck),
        .wbReq     (wbReq),
        .wbReg     (wbReg),
        .wbData    (wbData)
    );

    always #2 clock = ~clock;  // 4 ns period

    function automatic logic [dataWidth-1:0] encode(opcodeT op, regIndexT ra, regIndexT rb,
                                                    regIndexT rc, logic [immWidth-1:0] imm);
        return {op, ra, rb, rc, imm};
    endfunction

    task automatic addRow(logic [dataWidth-1:0] word, bit hasResult, regIndexT ra,
                          logic [dataWidth-1:0] value);
        wordTab.push_back(word);
        hasResultTab.push_back(hasResult);
        expRegTab.push_back(ra);
        expValTab.push_back(value);
    endtask

    task automatic addAlu(opcodeT op, regIndexT ra, regIndexT rb, regIndexT rc,
                          logic [dataWidth-1:0] value);
        addRow(encode(op, ra, rb, rc, 15'd0), 1'b1, ra, value);
    endtask

    task automatic addLdi(regIndexT ra, logic [immWidth-1:0] imm, logic [dataWidth-1:0] value);
        addRow(encode(opLdi, ra, 4'd0, 4'd0, imm), 1'b1, ra, value);
    endtask

    task automatic addNop(regIndexT ra, regIndexT rb, regIndexT rc);
        addRow(encode(opNop, ra, rb, rc, 15'h1234), 1'b0, ra, '0);  // Fields are ignored
    endtask

    // Expected values follow the ISA rules, registers start at zero
    task automatic buildTable();
        addLdi(4'd1, 15'd5, 32'h0000_0005);
        addLdi(4'd2, 15'h7ffd, 32'hffff_fffd);  // -3
        addLdi(4'd3, 15'h3fff, 32'h0000_3fff);  // Largest positive
        addLdi(4'd4, 15'h4000, 32'hffff_c000);  // Most negative
        addLdi(4'd5, 15'd1, 32'h0000_0001);
        addLdi(4'd6, 15'd31, 32'h0000_001f);
        addAlu(opAdd, 4'd8, 4'd1, 4'd2, 32'h0000_0002);
        addAlu(opSub, 4'd9, 4'd1, 4'd2, 32'h0000_0008);
        addAlu(opAnd, 4'd10, 4'd2, 4'd3, 32'h0000_3ffd);
        addAlu(opOr, 4'd11, 4'd3, 4'd4, 32'hffff_ffff);
        addAlu(opShr, 4'd12, 4'd1, 4'd5, 32'h0000_0002);  // 5 >> 1
        // Shift counts come from R5 = 1, R6 = 31 and R0 = 0
        addAlu(opShr, 4'd13, 4'd4, 4'd6, 32'h0000_0001);
        addAlu(opShra, 4'd13, 4'd4, 4'd5, 32'hffff_e000);
        addAlu(opShra, 4'd14, 4'd4, 4'd6, 32'hffff_ffff);
        addAlu(opShl, 4'd15, 4'd1, 4'd6, 32'h8000_0000);
        addAlu(opShl, 4'd15, 4'd2, 4'd0, 32'hffff_fffd);
        addAlu(opRor, 4'd12, 4'd1, 4'd5, 32'h8000_0002);
        addAlu(opRol, 4'd12, 4'd12, 4'd5, 32'h0000_0005);
        addAlu(opRol, 4'd9, 4'd1, 4'd6, 32'h8000_0002);
        addAlu(opRor, 4'd9, 4'd3, 4'd0, 32'h0000_3fff);
        addAlu(opNeg, 4'd1, 4'd2, 4'd4, 32'h0000_0003);  // Rc must not matter
        addAlu(opNot, 4'd2, 4'd3, 4'd11, 32'hffff_c000);
        addNop(4'd5, 4'd1, 4'd2);
        addAlu(opAdd, 4'd5, 4'd1, 4'd2, 32'hffff_c003);
        addNop(4'd7, 4'd7, 4'd7);
        burstStart = wordTab.size();
        addLdi(4'd0, 15'd100, 32'h0000_0064);
        addLdi(4'd1, 15'd200, 32'h0000_00c8);
        addAlu(opAdd, 4'd2, 4'd0, 4'd1, 32'h0000_012c);
        addAlu(opSub, 4'd3, 4'd0, 4'd1, 32'hffff_ff9c);
        addNop(4'd3, 4'd0, 4'd0);
        addAlu(opOr, 4'd4, 4'd2, 4'd3, 32'hffff_ffbc);
        addAlu(opAnd, 4'd5, 4'd2, 4'd3, 32'h0000_010c);
    endtask

    task automatic stopOnFailure(string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic checkValue(string name, logic [dataWidth-1:0] got,
                              logic [dataWidth-1:0] expected);
        assert (got === expected) else
            stopOnFailure($sformatf("CHECK FAILED at %0t ns: %s expected 0x%08h, got 0x%08h",
                                    $time, name, expected, got));
    endtask

    // Host side of the four-phase input link
    task automatic driveHost();
        int waited;
        for (int row = 0; row < wordTab.size(); row++) begin
            @(negedge clock);
            instrWord = wordTab[row];
            instrReq = 1'b1;
            waited = 0;
            do begin
                @(negedge clock);
                waited++;
            end while (!instrAck);
            if (waited > 1) stallCount++;  // Queue was full
            instrReq = 1'b0;
            do @(negedge clock); while (instrAck);
        end
    endtask

    task automatic collectResults();
        int delay;
        for (int row = 0; row < wordTab.size(); row++) begin
            if (hasResultTab[row]) begin
                while (!wbReq) @(negedge clock);
                checkValue("wbReg", {28'd0, wbReg}, {28'd0, expRegTab[row]});
                checkValue("wbData", wbData, expValTab[row]);
                // Slow acks in the burst let the queue fill up
                delay = (row >= burstStart) ? maxAckDelay : int'($urandom_range(maxAckDelay, 0));
                repeat (delay) @(negedge clock);
                wbAck = 1'b1;
                do @(negedge clock); while (wbReq);
                wbAck = 1'b0;
            end
        end
    endtask

    task automatic runWatchdog();
        int limit;
        limit = wordTab.size() * cyclesPerRow;
        repeat (limit) @(posedge clock);
        stopOnFailure($sformatf("Timeout after %0d cycles, the run did not complete", limit));
    endtask

    initial begin
        void'($urandom(32'hb6f8_eb98));
        clock = 1'b0;
        arstN = 1'b0;
        instrReq = 1'b0;
        instrWord = '0;
        wbAck = 1'b0;
        stallCount = 0;
        buildTable();
        repeat (resetCycles) @(negedge clock);
        arstN = 1'b1;
        fork
            runWatchdog();
        join_none
        fork
            driveHost();
            collectResults();
        join
        // No report may follow the last expected one
        repeat (20) begin
            @(negedge clock);
            assert (!wbReq) else stopOnFailure("An extra result was reported after the table");
        end
        // Full queue must have held off the host at least once
        if (stallCount > 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            stopOnFailure("The input link never stalled on a full queue");
        end
    end

endmodule

`default_nettype wire

// ==== design/cpuTop.sv ====
`default_nettype none

module cpuTop #(
    parameter int queueDepth = 4
) (
    input  logic                          clock,
    input  logic                          arstN,
    input  logic                          instrReq,
    input  logic [isaPkg::dataWidth-1:0]  instrWord,
    input  logic                          wbAck,
    output logic                          instrAck,
    output logic                          wbReq,
    output isaPkg::regIndexT              wbReg,
    output logic [isaPkg::dataWidth-1:0]  wbData
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic [dataWidth-1:0] headWord;
    logic queueEmpty;
    logic pop;
    busSrcT busSrc;
    regIndexT regSel;
    logic regWrite;
    logic yLoad;
    logic zLoad;
    opcodeT aluOp;
    logic [dataWidth-1:0] immValue;

    instrQueue #(
        .queueDepth (queueDepth)
    ) queue (
        .clock      (clock),
        .arstN      (arstN),
        .instrReq   (instrReq),
        .instrWord  (instrWord),
        .pop        (pop),
        .instrAck   (instrAck),
        .headWord   (headWord),
        .queueEmpty (queueEmpty)
    );

    stepControl sequencer (
        .clock      (clock),
        .arstN      (arstN),
        .headWord   (headWord),
        .queueEmpty (queueEmpty),
        .wbAck      (wbAck),
        .pop        (pop),
        .busSrc     (busSrc),
        .regSel     (regSel),
        .regWrite   (regWrite),
        .yLoad      (yLoad),
        .zLoad      (zLoad),
        .aluOp      (aluOp),
        .immValue   (immValue),
        .wbReq      (wbReq),
        .wbReg      (wbReg)
    );

    busDatapath datapath (
        .clock    (clock),
        .arstN    (arstN),
        .busSrc   (busSrc),
        .regSel   (regSel),
        .regWrite (regWrite),
        .yLoad    (yLoad),
        .zLoad    (zLoad),
        .aluOp    (aluOp),
        .immValue (immValue),
        .regWord  (wbData)  // Z latch drives the reported value
    );

endmodule

`default_nettype wire

// ==== design/busDatapath.sv ====
`default_nettype none

module busDatapath (
    input  logic                          clock,
    input  logic                          arstN,
    input  ctrlPkg::busSrcT               busSrc,
    input  isaPkg::regIndexT              regSel,
    input  logic                          regWrite,
    input  logic                          yLoad,
    input  logic                          zLoad,
    input  isaPkg::opcodeT                aluOp,
    input  logic [isaPkg::dataWidth-1:0]  immValue,
    output logic [isaPkg::dataWidth-1:0]  regWord
);
    import isaPkg::*;
    import ctrlPkg::*;

    localparam int numRegs = 2 ** $bits(regIndexT);

    logic [dataWidth-1:0] regFile [numRegs];
    logic [dataWidth-1:0] busValue;
    logic [dataWidth-1:0] yReg;
    logic [dataWidth-1:0] zReg;
    logic [dataWidth-1:0] aluResult;

    assign regWord = zReg;  // Result reported to the host

    // Single shared bus
    always_comb begin
        case (busSrc)
            busReg:  busValue = regFile[regSel];
            busZ:    busValue = zReg;
            busImm:  busValue = immValue;
            default: busValue = '0;
        endcase
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regFile[i] <= '0;
            end
        end else if (regWrite) begin
            regFile[regSel] <= busValue;
        end
    end

    always_ff @(posedge clock) begin
        if (yLoad) yReg <= busValue;
        if (zLoad) zReg <= aluResult;
    end

    aluUnit alu (
        .aluOp    (aluOp),
        .yValue   (yReg),
        .busValue (busValue),
        .result   (aluResult)
    );

    // Sequencer never loads from an idle bus
    busDrivenOnLoad: assert property (@(posedge clock) disable iff (!arstN)
        (yLoad || zLoad || regWrite) |-> !$isunknown(busSrc) && (busSrc != busNone));

endmodule

`default_nettype wire

// ==== design/aluUnit.sv ====
`default_nettype none

module aluUnit (
    input  isaPkg::opcodeT                aluOp,
    input  logic [isaPkg::dataWidth-1:0]  yValue,
    input  logic [isaPkg::dataWidth-1:0]  busValue,
    output logic [isaPkg::dataWidth-1:0]  result
);
    import isaPkg::*;

    logic [4:0] shiftCount;
    logic [2*dataWidth-1:0] doubled;
    logic [2*dataWidth-1:0] rorWide;
    logic [2*dataWidth-1:0] rolWide;

    assign shiftCount = busValue[4:0];  // Rc[4:0]

    // Rotates come from a doubled copy of Y
    assign doubled = {yValue, yValue};
    assign rorWide = doubled >> shiftCount;
    assign rolWide = doubled << shiftCount;

    always_comb begin
        case (aluOp)
            opAdd:   result = yValue + busValue;
            opSub:   result = yValue - busValue;
            opAnd:   result = yValue & busValue;
            opOr:    result = yValue | busValue;
            opShr:   result = yValue >> shiftCount;
            opShra:  result = $signed(yValue) >>> shiftCount;
            opShl:   result = yValue << shiftCount;
            opRor:   result = rorWide[dataWidth-1:0];
            opRol:   result = rolWide[2*dataWidth-1:dataWidth];
            opNeg:   result = '0 - yValue;  // Y holds Rb
            opNot:   result = ~yValue;
            opLdi:   result = busValue;  // Immediate passes through
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/stepControl.sv ====
`default_nettype none

module stepControl (
    input  logic                          clock,
    input  logic                          arstN,
    input  logic [isaPkg::dataWidth-1:0]  headWord,
    input  logic                          queueEmpty,
    input  logic                          wbAck,
    output logic                          pop,
    output ctrlPkg::busSrcT               busSrc,
    output isaPkg::regIndexT              regSel,
    output logic                          regWrite,
    output logic                          yLoad,
    output logic                          zLoad,
    output isaPkg::opcodeT                aluOp,
    output logic [isaPkg::dataWidth-1:0]  immValue,
    output logic                          wbReq,
    output isaPkg::regIndexT              wbReg
);
    import isaPkg::*;
    import ctrlPkg::*;

    stepT step;
    stepT stepNext;
    logic [dataWidth-1:0] ir;
    opcodeT irOp;

    assign irOp = fieldOp(ir);
    assign aluOp = irOp;
    assign immValue = fieldImm(ir);
    assign wbReg = fieldReg(ir, raLsb);

    assign pop = (step == stepFetch);
    assign wbReq = (step == stepWrite) || (step == stepWaitAck);

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            ir <= '0;
        end else if (pop) begin
            ir <= headWord;  // Head is popped on this same edge
        end
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) step <= stepIdle;
        else        step <= stepNext;
    end

    always_comb begin
        stepNext = step;
        case (step)
            stepIdle: if (!queueEmpty) stepNext = stepFetch;
            stepFetch: begin
                // Decode straight from the head, IR is not loaded yet
                case (fieldOp(headWord))
                    opNop:   stepNext = stepIdle;
                    opLdi:   stepNext = stepExec;
                    default: stepNext = stepRbToY;
                endcase
            end
            stepRbToY: stepNext = stepExec;
            stepExec:  stepNext = stepWrite;
            stepWrite: stepNext = stepWaitAck;
            stepWaitAck: if (wbAck) stepNext = stepWaitRelease;
            stepWaitRelease: begin
                if (!wbAck) stepNext = queueEmpty ? stepIdle : stepFetch;
            end
            default: stepNext = stepIdle;
        endcase
    end

    // Bus source and latch enables for each step
    always_comb begin
        busSrc = busNone;
        regSel = fieldReg(ir, raLsb);
        regWrite = 1'b0;
        yLoad = 1'b0;
        zLoad = 1'b0;
        case (step)
            stepRbToY: begin
                busSrc = busReg;
                regSel = fieldReg(ir, rbLsb);
                yLoad = 1'b1;
            end
            stepExec: begin
                zLoad = 1'b1;
                if (irOp == opLdi) begin
                    busSrc = busImm;  // Passed through the ALU
                end else begin
                    busSrc = busReg;
                    regSel = fieldReg(ir, rcLsb);
                end
            end
            stepWrite: begin
                busSrc = busZ;
                regWrite = 1'b1;
            end
            default: ;
        endcase
    end

    // Host samples wbReg across the whole request
    wbRegStable: assert property (@(posedge clock) disable iff (!arstN)
        wbReq ##1 wbReq |-> $stable(wbReg));

    writeOnlyInWrite: assert property (@(posedge clock) disable iff (!arstN)
        regWrite |-> (step == stepWrite) && wbReq && (irOp != opNop));

endmodule

`default_nettype wire

// ==== design/instrQueue.sv ====
`default_nettype none

module instrQueue #(
    parameter int queueDepth = 4
) (
    input  logic                          clock,
    input  logic                          arstN,
    input  logic                          instrReq,
    input  logic [isaPkg::dataWidth-1:0]  instrWord,
    input  logic                          pop,
    output logic                          instrAck,
    output logic [isaPkg::dataWidth-1:0]  headWord,
    output logic                          queueEmpty
);
    import isaPkg::*;

    localparam int ptrWidth = (queueDepth > 1) ? $clog2(queueDepth) : 1;
    localparam int countWidth = $clog2(queueDepth + 1);

    typedef enum logic {
        acceptIdle,
        acceptHold   // Word stored, ack high until req drops
    } acceptStateT;

    acceptStateT acceptState;

    logic [dataWidth-1:0] mem [queueDepth];
    logic [ptrWidth-1:0] rdPtr;
    logic [ptrWidth-1:0] wrPtr;
    logic [countWidth-1:0] count;
    logic queueFull;
    logic push;

    assign queueEmpty = (count == '0);
    assign queueFull = (count == countWidth'(queueDepth));
    assign headWord = mem[rdPtr];
    assign instrAck = (acceptState == acceptHold);

    // One word per request, and only with room left
    assign push = (acceptState == acceptIdle) && instrReq && !queueFull;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            acceptState <= acceptIdle;
        end else begin
            case (acceptState)
                acceptIdle: if (push) acceptState <= acceptHold;
                acceptHold: if (!instrReq) acceptState <= acceptIdle;
                default:    acceptState <= acceptIdle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push) mem[wrPtr] <= instrWord;
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == ptrWidth'(queueDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == ptrWidth'(queueDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

    // Sequencer must only fetch what is there
    noPopWhenEmpty: assert property (@(posedge clock) disable iff (!arstN)
        pop |-> !queueEmpty);

    countInRange: assert property (@(posedge clock) disable iff (!arstN)
        count <= countWidth'(queueDepth));

endmodule

`default_nettype wire

// ==== design/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

    // Control steps of the sequencer
    typedef enum logic [2:0] {
        stepIdle,          // Waiting for a queued instruction
        stepFetch,         // IR loads from queue head
        stepRbToY,         // Rb over the bus into Y
        stepExec,          // ALU result into Z
        stepWrite,         // Z into Ra, result offered
        stepWaitAck,       // Host has not taken the result yet
        stepWaitRelease    // Waiting for wbAck to fall
    } stepT;

    // Who drives the shared bus
    typedef enum logic [1:0] {
        busNone,   // Bus idles at zero
        busReg,    // Register selected by regSel
        busZ,      // Result latch
        busImm     // Sign-extended immediate from IR
    } busSrcT;

endpackage

`default_nettype wire

// ==== design/isaPkg.sv ====
`default_nettype none

package isaPkg;

    localparam int dataWidth = 32;  // Instruction words, registers and bus
    localparam int immWidth = 15;

    // Field positions inside an instruction word
    localparam int opLsb = 27;
    localparam int raLsb = 23;  // Destination
    localparam int rbLsb = 19;
    localparam int rcLsb = 15;

    typedef logic [3:0] regIndexT;  // R0 to R15

    // Gaps belong to memory, multiply/divide, branch and I/O instructions
    typedef enum logic [4:0] {
        opLdi = 5'b00001,
        opAdd = 5'b00011,
        opSub = 5'b00100,
        opShr = 5'b00101,
        opShra = 5'b00110,
        opShl = 5'b00111,
        opRor = 5'b01000,
        opRol = 5'b01001,
        opAnd = 5'b01010,
        opOr = 5'b01011,
        opNeg = 5'b10001,
        opNot = 5'b10010,
        opNop = 5'b11010
    } opcodeT;

    function automatic opcodeT fieldOp(input logic [dataWidth-1:0] word);
        return opcodeT'(word[opLsb +: $bits(opcodeT)]);
    endfunction

    function automatic regIndexT fieldReg(input logic [dataWidth-1:0] word, input int lsb);
        return regIndexT'(word[lsb +: $bits(regIndexT)]);
    endfunction

    // Immediate is sign extended to the full word
    function automatic logic [dataWidth-1:0] fieldImm(input logic [dataWidth-1:0] word);
        return {{(dataWidth - immWidth){word[immWidth-1]}}, word[immWidth-1:0]};
    endfunction

endpackage

`default_nettype wire
